/* proc.f */
+incdir+source
source/proc_pkg.sv
source/fetch.sv
source/decode.sv
source/execution.sv
source/memory.sv
source/proc.sv
test/proc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the processor testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f proc.f --top-module proc_tb -o proc_sim \
   && ./obj_dir/proc_sim | tee sim.log \
   || { echo "build or run of the simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* test/proc_tb.sv */
// processor core testbench
`include "proc_defs.svh"

module proc_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import proc_pkg::*;

   localparam int word_w      = `PROC_WORD_W;
   localparam int reg_aw      = `PROC_REG_AW;
   localparam int num_tests   = 13;
   localparam int cycle_limit = num_tests * 40;
   localparam logic [word_w-1:0] halt_word = '0;

   logic              clk = 1'b0;
   logic              rst = 1'b1;
   logic [word_w-1:0] imem_data = '0;
   logic [word_w-1:0] imem_addr;
   logic              wb_en;
   logic [reg_aw-1:0] wb_reg;
   logic [word_w-1:0] wb_data;
   logic              halt;
   logic              err;

   // test table
   string             names [num_tests];
   logic [word_w-1:0] progs [num_tests][12];
   int                prog_len [num_tests];
   logic [reg_aw-1:0] exp_reg [num_tests][10];
   logic [word_w-1:0] exp_val [num_tests][10];
   int                exp_cnt [num_tests];
   logic              exp_err [num_tests];

   // observed writeback trace of the running test
   logic [reg_aw-1:0] got_reg [$];
   logic [word_w-1:0] got_val [$];

   int          fill = -1;
   int          cur = 0;
   int          errors = 0;
   int          passed = 0;
   int          cycles = 0;
   logic [31:0] rand_state = 32'd38;

   proc dut0 (
      .clk(clk), .rst(rst), .imem_data(imem_data), .imem_addr(imem_addr),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt), .err(err)
   );

   always #20 clk = ~clk;

   // instruction memory served from the table, past the end reads as halt
   function automatic logic [word_w-1:0] imem_word(input logic [word_w-1:0] addr);
      int idx;
      idx = int'(addr[word_w-1:1]);
      if (idx < prog_len[cur]) begin
         return progs[cur][idx];
      end
      return halt_word;
   endfunction

   always @(posedge clk) begin
      #1;
      imem_data = imem_word(imem_addr);
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32();
      rand_state = rand_state ^ (rand_state << 13);
      rand_state = rand_state ^ (rand_state >> 17);
      rand_state = rand_state ^ (rand_state << 5);
      return rand_state;
   endfunction

   // instruction formats
   function automatic logic [word_w-1:0] r_word(input opcode_e op, input logic [reg_aw-1:0] rd,
                                                input logic [reg_aw-1:0] rs,
                                                input logic [reg_aw-1:0] rt);
      return {op, rd, rs, rt, 2'b00};
   endfunction

   function automatic logic [word_w-1:0] i5_word(input opcode_e op, input logic [reg_aw-1:0] rd,
                                                 input logic [reg_aw-1:0] rs,
                                                 input logic [4:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [word_w-1:0] i8_word(input opcode_e op, input logic [reg_aw-1:0] rd,
                                                 input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic logic [word_w-1:0] j_word(input logic [10:0] off);
      return {op_j, off};
   endfunction

   task automatic start_entry(input string name, input logic err_exp);
      int i;
      fill = fill + 1;
      names[fill]    = name;
      prog_len[fill] = 0;
      exp_cnt[fill]  = 0;
      exp_err[fill]  = err_exp;
      for (i = 0; i < 12; i++) begin
         progs[fill][i] = halt_word;
      end
   endtask

   task automatic push_instr(input logic [word_w-1:0] word);
      progs[fill][prog_len[fill]] = word;
      prog_len[fill] = prog_len[fill] + 1;
   endtask

   task automatic expect_write(input logic [reg_aw-1:0] rd, input logic [word_w-1:0] value);
      exp_reg[fill][exp_cnt[fill]] = rd;
      exp_val[fill][exp_cnt[fill]] = value;
      exp_cnt[fill] = exp_cnt[fill] + 1;
   endtask

   // lbi seeds then back to back add or xor, values by the ISA rules
   task automatic make_random(input int k);
      logic [7:0]        written;
      logic [word_w-1:0] model [8];
      logic [31:0]       r;
      logic [reg_aw-1:0] rd;
      logic [reg_aw-1:0] rs;
      logic [reg_aw-1:0] rt;
      logic [7:0]        imm;
      logic [word_w-1:0] value;
      opcode_e           op;
      written = '0;
      start_entry($sformatf("random_%0d", k), 1'b0);
      repeat (3) begin
         r     = xorshift32();
         rd    = r[10:8];
         imm   = r[7:0];
         value = {{(word_w-8){imm[7]}}, imm};
         push_instr(i8_word(op_lbi, rd, imm));
         expect_write(rd, value);
         model[rd]   = value;
         written[rd] = 1'b1;
      end
      repeat (5) begin
         r  = xorshift32();
         rd = r[10:8];
         rs = r[7:5];
         rt = r[4:2];
         // only read registers that hold a value
         while (!written[rs]) begin
            rs = rs + 3'd1;
         end
         while (!written[rt]) begin
            rt = rt + 3'd1;
         end
         if (r[16]) begin
            op    = op_xor;
            value = model[rs] ^ model[rt];
         end else begin
            op    = op_add;
            value = model[rs] + model[rt];
         end
         push_instr(r_word(op, rd, rs, rt));
         expect_write(rd, value);
         model[rd]   = value;
         written[rd] = 1'b1;
      end
      push_instr(halt_word);
   endtask

   task automatic build_table();
      int k;
      // dependent alu chain through both forwarding paths
      start_entry("alu_chain", 1'b0);
      push_instr(i8_word(op_lbi, 3'd1, 8'h05));
      push_instr(i8_word(op_lbi, 3'd2, 8'hFD));
      push_instr(r_word(op_add, 3'd3, 3'd1, 3'd2));
      push_instr(r_word(op_sub, 3'd4, 3'd3, 3'd1));
      push_instr(r_word(op_and, 3'd5, 3'd4, 3'd1));
      push_instr(r_word(op_xor, 3'd6, 3'd5, 3'd4));
      push_instr(i5_word(op_addi, 3'd7, 3'd6, 5'h07));
      push_instr(i5_word(op_addi, 3'd1, 3'd7, 5'h10));
      push_instr(halt_word);
      expect_write(3'd1, 16'h0005);
      expect_write(3'd2, 16'hFFFD);
      expect_write(3'd3, 16'h0002);
      expect_write(3'd4, 16'hFFFD);
      expect_write(3'd5, 16'h0005);
      expect_write(3'd6, 16'hFFF8);
      expect_write(3'd7, 16'hFFFF);
      expect_write(3'd1, 16'hFFEF);
      // store then load, each load followed by a user
      start_entry("store_load", 1'b0);
      push_instr(i8_word(op_lbi, 3'd1, 8'h64));
      push_instr(i8_word(op_lbi, 3'd2, 8'hA5));
      push_instr(i5_word(op_st, 3'd2, 3'd1, 5'h03));
      push_instr(i5_word(op_ld, 3'd3, 3'd1, 5'h03));
      push_instr(r_word(op_add, 3'd4, 3'd3, 3'd1));
      push_instr(i5_word(op_ld, 3'd5, 3'd1, 5'h03));
      push_instr(i5_word(op_st, 3'd5, 3'd1, 5'h04));
      push_instr(i5_word(op_ld, 3'd6, 3'd1, 5'h04));
      push_instr(halt_word);
      expect_write(3'd1, 16'h0064);
      expect_write(3'd2, 16'hFFA5);
      expect_write(3'd3, 16'hFFA5);
      expect_write(3'd4, 16'h0009);
      expect_write(3'd5, 16'hFFA5);
      expect_write(3'd6, 16'hFFA5);
      // not taken beqz, taken beqz to word 6, j to word 10
      start_entry("branch_jump", 1'b0);
      push_instr(i8_word(op_lbi, 3'd1, 8'h00));
      push_instr(i8_word(op_lbi, 3'd2, 8'h01));
      push_instr(i8_word(op_beqz, 3'd2, 8'h04));
      push_instr(i8_word(op_beqz, 3'd1, 8'h02));
      push_instr(i8_word(op_lbi, 3'd3, 8'h11));
      push_instr(i8_word(op_lbi, 3'd4, 8'h22));
      push_instr(i8_word(op_lbi, 3'd5, 8'h33));
      push_instr(j_word(11'd2));
      push_instr(i8_word(op_lbi, 3'd3, 8'h44));
      push_instr(i8_word(op_lbi, 3'd4, 8'h55));
      push_instr(r_word(op_add, 3'd6, 3'd7, 3'd5));
      push_instr(halt_word);
      expect_write(3'd1, 16'h0000);
      expect_write(3'd2, 16'h0001);
      expect_write(3'd5, 16'h0033);
      expect_write(3'd7, 16'h0010);
      expect_write(3'd6, 16'h0043);
      // opcode 5'b11111 is not in the ISA
      start_entry("illegal_opcode", 1'b1);
      push_instr(i8_word(op_lbi, 3'd1, 8'h09));
      push_instr(16'hF800);
      push_instr(i8_word(op_lbi, 3'd2, 8'h0A));
      push_instr(halt_word);
      expect_write(3'd1, 16'h0009);
      expect_write(3'd2, 16'h000A);
      // words behind the halt never write back
      start_entry("halt_hold", 1'b0);
      push_instr(i8_word(op_lbi, 3'd1, 8'h7F));
      push_instr(i5_word(op_addi, 3'd2, 3'd1, 5'h01));
      push_instr(halt_word);
      push_instr(i8_word(op_lbi, 3'd3, 8'h01));
      push_instr(r_word(op_add, 3'd4, 3'd1, 3'd2));
      expect_write(3'd1, 16'h007F);
      expect_write(3'd2, 16'h0080);
      for (k = 0; k < 8; k++) begin
         make_random(k);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic run_entry(input int t);
      int n;
      int errors_before;
      errors_before = errors;
      cur = t;
      got_reg.delete();
      got_val.delete();
      apply_reset();
      if (halt || wb_en || err || imem_addr !== '0) begin
         $display("[FAIL] t=%0d ns: %0s outputs not cleared by reset", $time, names[t]);
         errors++;
      end
      while (!halt) begin
         @(posedge clk);
         #1;
         if (wb_en) begin
            got_reg.push_back(wb_reg);
            got_val.push_back(wb_data);
         end
      end
      // pipeline frozen after halt
      repeat (10) begin
         @(posedge clk);
         #1;
         if (!halt || wb_en || err !== exp_err[t]) begin
            $display("[FAIL] t=%0d ns: %0s after halt got halt=%b wb_en=%b err=%b, err expected %b",
                     $time, names[t], halt, wb_en, err, exp_err[t]);
            errors++;
         end
      end
      if (got_reg.size() != exp_cnt[t]) begin
         $display("[FAIL] t=%0d ns: %0s saw %0d writebacks, expected %0d",
                  $time, names[t], got_reg.size(), exp_cnt[t]);
         errors++;
      end
      for (n = 0; n < exp_cnt[t] && n < got_reg.size(); n++) begin
         if (got_reg[n] !== exp_reg[t][n] || got_val[n] !== exp_val[t][n]) begin
            $display("[FAIL] t=%0d ns: %0s writeback %0d got r%0d=%h, expected r%0d=%h",
                     $time, names[t], n, got_reg[n], got_val[n], exp_reg[t][n], exp_val[t][n]);
            errors++;
         end
      end
      if (errors == errors_before) begin
         passed++;
         $display("test %0s: ok, %0d writebacks", names[t], got_reg.size());
      end else begin
         $display("test %0s: failed", names[t]);
      end
   endtask

   initial begin
      int t;
      build_table();
      for (t = 0; t < num_tests; t++) begin
         run_entry(t);
      end
      $display("%0d of %0d tests ok, %0d failed checks", passed, num_tests, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* source/proc.sv */
// five-stage processor core
`include "proc_defs.svh"

module proc (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`PROC_WORD_W-1:0] imem_data,
   output logic [`PROC_WORD_W-1:0] imem_addr,
   output logic                    wb_en,
   output logic [`PROC_REG_AW-1:0] wb_reg,
   output logic [`PROC_WORD_W-1:0] wb_data,
   output logic                    halt,
   output logic                    err
);
   import proc_pkg::*;

   // IF/ID
   logic [`PROC_WORD_W-1:0] if_instr;
   logic [`PROC_WORD_W-1:0] if_pc2;

   // ID/EX
   opcode_e                 id_opcode;
   alu_op_e                 id_alu_op;
   wb_src_e                 id_wb_src;
   logic [`PROC_WORD_W-1:0] id_rs_val;
   logic [`PROC_WORD_W-1:0] id_rt_val;
   logic [`PROC_WORD_W-1:0] id_rd_val;
   logic [`PROC_WORD_W-1:0] id_imm;
   logic [`PROC_WORD_W-1:0] id_pc2;
   logic [`PROC_REG_AW-1:0] id_rs;
   logic [`PROC_REG_AW-1:0] id_rt;
   logic [`PROC_REG_AW-1:0] id_rd;
   logic                    id_reg_wr;
   logic                    id_mem_rd;
   logic                    id_mem_wr;
   logic                    stall;

   // redirect from EX
   logic                    flush;
   logic [`PROC_WORD_W-1:0] next_pc;

   // EX/MEM
   logic [`PROC_WORD_W-1:0] ex_result;
   logic [`PROC_WORD_W-1:0] ex_store;
   logic [`PROC_WORD_W-1:0] ex_pc2;
   logic [`PROC_REG_AW-1:0] ex_rd;
   logic                    ex_reg_wr;
   logic                    ex_mem_rd;
   logic                    ex_mem_wr;
   logic                    ex_halt;
   wb_src_e                 ex_wb_src;

   fetch fetch0 (
      .clk(clk), .rst(rst), .stall(stall), .flush(flush), .halt(halt),
      .next_pc(next_pc), .imem_data(imem_data), .imem_addr(imem_addr),
      .if_instr(if_instr), .if_pc2(if_pc2)
   );

   decode decode0 (
      .clk(clk), .rst(rst), .if_instr(if_instr), .if_pc2(if_pc2),
      .flush(flush), .halt(halt),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .id_opcode(id_opcode), .id_alu_op(id_alu_op), .id_wb_src(id_wb_src),
      .id_rs_val(id_rs_val), .id_rt_val(id_rt_val), .id_rd_val(id_rd_val),
      .id_imm(id_imm), .id_pc2(id_pc2),
      .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd),
      .id_reg_wr(id_reg_wr), .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr),
      .stall(stall)
   );

   // EX/MEM forwarding source is the stage's own register
   execution exec0 (
      .clk(clk), .rst(rst), .halt(halt),
      .id_opcode(id_opcode), .id_alu_op(id_alu_op), .id_wb_src(id_wb_src),
      .id_rs_val(id_rs_val), .id_rt_val(id_rt_val), .id_rd_val(id_rd_val),
      .id_imm(id_imm), .id_pc2(id_pc2),
      .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd),
      .id_reg_wr(id_reg_wr), .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr),
      .mem_rd_fwd_en(ex_reg_wr), .mem_reg(ex_rd), .mem_result(ex_result),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .flush(flush), .next_pc(next_pc),
      .ex_result(ex_result), .ex_store(ex_store), .ex_pc2(ex_pc2), .ex_rd(ex_rd),
      .ex_reg_wr(ex_reg_wr), .ex_mem_rd(ex_mem_rd), .ex_mem_wr(ex_mem_wr),
      .ex_halt(ex_halt), .ex_wb_src(ex_wb_src), .err(err)
   );

   memory memory0 (
      .clk(clk), .rst(rst),
      .ex_result(ex_result), .ex_store(ex_store), .ex_pc2(ex_pc2), .ex_rd(ex_rd),
      .ex_reg_wr(ex_reg_wr), .ex_mem_rd(ex_mem_rd), .ex_mem_wr(ex_mem_wr),
      .ex_halt(ex_halt), .ex_wb_src(ex_wb_src),
      .halt(halt), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

endmodule

/* source/memory.sv */
// data memory stage
`include "proc_defs.svh"

module memory (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`PROC_WORD_W-1:0] ex_result,
   input  logic [`PROC_WORD_W-1:0] ex_store,
   input  logic [`PROC_WORD_W-1:0] ex_pc2,
   input  logic [`PROC_REG_AW-1:0] ex_rd,
   input  logic                    ex_reg_wr,
   input  logic                    ex_mem_rd,
   input  logic                    ex_mem_wr,
   input  logic                    ex_halt,
   input  proc_pkg::wb_src_e       ex_wb_src,
   output logic                    halt,
   output logic                    wb_en,
   output logic [`PROC_REG_AW-1:0] wb_reg,
   output logic [`PROC_WORD_W-1:0] wb_data
);
   import proc_pkg::*;

   localparam int dmem_aw = $clog2(`PROC_DMEM_WORDS);

   logic [`PROC_WORD_W-1:0] dmem [`PROC_DMEM_WORDS];
   logic [dmem_aw-1:0]      addr;
   logic [`PROC_WORD_W-1:0] rd_word;
   logic [`PROC_WORD_W-1:0] wb_value;

   // word address wraps at the array depth
   assign addr    = ex_result[dmem_aw-1:0];
   assign rd_word = ex_mem_rd ? dmem[addr] : '0;

   always_ff @(posedge clk) begin
      if (ex_mem_wr && !halt) begin
         dmem[addr] <= ex_store;
      end
   end

   always_comb begin
      case (ex_wb_src)
         wb_mem:  wb_value = rd_word;
         wb_pc2:  wb_value = ex_pc2;
         default: wb_value = ex_result;
      endcase
   end

   // halt latches here and freezes the whole pipe
   always_ff @(posedge clk) begin
      if (rst) begin
         halt  <= 1'b0;
         wb_en <= 1'b0;
      end else if (halt) begin
         wb_en <= 1'b0;
      end else begin
         halt  <= ex_halt;
         wb_en <= ex_reg_wr;
      end
   end

   // MEM/WB payload
   always_ff @(posedge clk) begin
      if (!halt) begin
         wb_reg  <= ex_rd;
         wb_data <= wb_value;
      end
   end

endmodule

/* source/execution.sv */
// execution stage
`include "proc_defs.svh"

module execution (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    halt,
   input  proc_pkg::opcode_e       id_opcode,
   input  proc_pkg::alu_op_e       id_alu_op,
   input  proc_pkg::wb_src_e       id_wb_src,
   input  logic [`PROC_WORD_W-1:0] id_rs_val,
   input  logic [`PROC_WORD_W-1:0] id_rt_val,
   input  logic [`PROC_WORD_W-1:0] id_rd_val,
   input  logic [`PROC_WORD_W-1:0] id_imm,
   input  logic [`PROC_WORD_W-1:0] id_pc2,
   input  logic [`PROC_REG_AW-1:0] id_rs,
   input  logic [`PROC_REG_AW-1:0] id_rt,
   input  logic [`PROC_REG_AW-1:0] id_rd,
   input  logic                    id_reg_wr,
   input  logic                    id_mem_rd,
   input  logic                    id_mem_wr,
   input  logic                    mem_rd_fwd_en,
   input  logic [`PROC_REG_AW-1:0] mem_reg,
   input  logic [`PROC_WORD_W-1:0] mem_result,
   input  logic                    wb_en,
   input  logic [`PROC_REG_AW-1:0] wb_reg,
   input  logic [`PROC_WORD_W-1:0] wb_data,
   output logic                    flush,
   output logic [`PROC_WORD_W-1:0] next_pc,
   output logic [`PROC_WORD_W-1:0] ex_result,
   output logic [`PROC_WORD_W-1:0] ex_store,
   output logic [`PROC_WORD_W-1:0] ex_pc2,
   output logic [`PROC_REG_AW-1:0] ex_rd,
   output logic                    ex_reg_wr,
   output logic                    ex_mem_rd,
   output logic                    ex_mem_wr,
   output logic                    ex_halt,
   output proc_pkg::wb_src_e       ex_wb_src,
   output logic                    err
);
   import proc_pkg::*;

   logic [`PROC_WORD_W-1:0] rs_fwd;
   logic [`PROC_WORD_W-1:0] rt_fwd;
   logic [`PROC_WORD_W-1:0] rd_fwd;
   logic [`PROC_WORD_W-1:0] alu_a;
   logic [`PROC_WORD_W-1:0] alu_b;
   logic [`PROC_WORD_W-1:0] alu_out;
   logic                    legal;
   logic                    kill;

   // nearest older producer wins
   function automatic logic [`PROC_WORD_W-1:0] fwd(input logic [`PROC_REG_AW-1:0] idx,
                                                    input logic [`PROC_WORD_W-1:0] rf_val);
      if (mem_rd_fwd_en && mem_reg == idx) begin
         return mem_result;
      end else if (wb_en && wb_reg == idx) begin
         return wb_data;
      end
      return rf_val;
   endfunction

   always_comb begin
      rs_fwd = fwd(id_rs, id_rs_val);
      rt_fwd = fwd(id_rt, id_rt_val);
      rd_fwd = fwd(id_rd, id_rd_val);
   end

   // alu operand select
   always_comb begin
      alu_a = rs_fwd;
      alu_b = id_imm;
      case (id_opcode)
         op_add, op_sub, op_and, op_xor: alu_b = rt_fwd;
         op_lbi: alu_a = '0;
         default: ;
      endcase
   end

   always_comb begin
      case (id_alu_op)
         alu_sub: alu_out = alu_a - alu_b;
         alu_and: alu_out = alu_a & alu_b;
         alu_xor: alu_out = alu_a ^ alu_b;
         default: alu_out = alu_a + alu_b;
      endcase
   end

   assign legal = id_opcode inside {op_nop, op_halt, op_add, op_sub, op_and, op_xor,
                                    op_addi, op_lbi, op_ld, op_st, op_beqz, op_j};

   // anything behind a halt in MEM is dead
   assign kill = halt || ex_halt;

   // branch and jump resolution
   assign flush   = !kill && (id_opcode == op_j || (id_opcode == op_beqz && rd_fwd == '0));
   assign next_pc = id_pc2 + {id_imm[`PROC_WORD_W-2:0], 1'b0};

   // EX/MEM control
   always_ff @(posedge clk) begin
      if (rst) begin
         ex_reg_wr <= 1'b0;
         ex_mem_rd <= 1'b0;
         ex_mem_wr <= 1'b0;
         ex_halt   <= 1'b0;
         err       <= 1'b0;
      end else if (!kill) begin
         ex_reg_wr <= id_reg_wr;
         ex_mem_rd <= id_mem_rd;
         ex_mem_wr <= id_mem_wr;
         ex_halt   <= (id_opcode == op_halt);
         // sticky until reset
         err       <= err || !legal;
      end
   end

   // EX/MEM payload
   always_ff @(posedge clk) begin
      if (!kill) begin
         ex_result <= alu_out;
         ex_store  <= rd_fwd;
         ex_pc2    <= id_pc2;
         ex_rd     <= id_rd;
         ex_wb_src <= id_wb_src;
      end
   end

endmodule

/* source/decode.sv */
// instruction decode stage
`include "proc_defs.svh"

module decode (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`PROC_WORD_W-1:0] if_instr,
   input  logic [`PROC_WORD_W-1:0] if_pc2,
   input  logic                    flush,
   input  logic                    halt,
   input  logic                    wb_en,
   input  logic [`PROC_REG_AW-1:0] wb_reg,
   input  logic [`PROC_WORD_W-1:0] wb_data,
   output proc_pkg::opcode_e       id_opcode,
   output proc_pkg::alu_op_e       id_alu_op,
   output proc_pkg::wb_src_e       id_wb_src,
   output logic [`PROC_WORD_W-1:0] id_rs_val,
   output logic [`PROC_WORD_W-1:0] id_rt_val,
   output logic [`PROC_WORD_W-1:0] id_rd_val,
   output logic [`PROC_WORD_W-1:0] id_imm,
   output logic [`PROC_WORD_W-1:0] id_pc2,
   output logic [`PROC_REG_AW-1:0] id_rs,
   output logic [`PROC_REG_AW-1:0] id_rt,
   output logic [`PROC_REG_AW-1:0] id_rd,
   output logic                    id_reg_wr,
   output logic                    id_mem_rd,
   output logic                    id_mem_wr,
   output logic                    stall
);
   import proc_pkg::*;

   logic [`PROC_WORD_W-1:0] rf [`PROC_REG_CNT];

   opcode_e                 opcode;
   alu_op_e                 alu_op;
   wb_src_e                 wb_src;
   logic [`PROC_REG_AW-1:0] rd_f;
   logic [`PROC_REG_AW-1:0] rs_f;
   logic [`PROC_REG_AW-1:0] rt_f;
   logic [`PROC_REG_AW-1:0] dst;
   logic [`PROC_WORD_W-1:0] imm5;
   logic [`PROC_WORD_W-1:0] imm8;
   logic [`PROC_WORD_W-1:0] imm11;
   logic [`PROC_WORD_W-1:0] imm;
   logic [`PROC_WORD_W-1:0] rs_val;
   logic [`PROC_WORD_W-1:0] rt_val;
   logic [`PROC_WORD_W-1:0] rd_val;
   logic                    use_rs;
   logic                    use_rt;
   logic                    use_rd;
   logic                    reg_wr;

   // write first, so a same-cycle writeback is seen here
   function automatic logic [`PROC_WORD_W-1:0] rf_read(input logic [`PROC_REG_AW-1:0] idx);
      if (wb_en && wb_reg == idx) begin
         return wb_data;
      end
      return rf[idx];
   endfunction

   // instruction fields
   assign opcode = opcode_e'(if_instr[15:11]);
   assign rd_f   = if_instr[10:8];
   assign rs_f   = if_instr[7:5];
   assign rt_f   = if_instr[4:2];
   assign imm5   = {{(`PROC_WORD_W-5){if_instr[4]}}, if_instr[4:0]};
   assign imm8   = {{(`PROC_WORD_W-8){if_instr[7]}}, if_instr[7:0]};
   assign imm11  = {{(`PROC_WORD_W-11){if_instr[10]}}, if_instr[10:0]};

   always_comb begin
      alu_op = alu_add;
      imm    = imm5;
      case (opcode)
         op_sub: alu_op = alu_sub;
         op_and: alu_op = alu_and;
         op_xor: alu_op = alu_xor;
         op_lbi, op_beqz: imm = imm8;
         op_j: imm = imm11;
         default: ;
      endcase
   end

   assign wb_src = (opcode == op_ld) ? wb_mem : (opcode == op_j) ? wb_pc2 : wb_alu;
   assign reg_wr = opcode inside {op_add, op_sub, op_and, op_xor, op_addi, op_lbi, op_ld, op_j};
   assign use_rt = opcode inside {op_add, op_sub, op_and, op_xor};
   assign use_rs = use_rt || (opcode inside {op_addi, op_ld, op_st});
   assign use_rd = opcode inside {op_st, op_beqz};
   // j links into r7
   assign dst    = (opcode == op_j) ? {`PROC_REG_AW{1'b1}} : rd_f;

   always_comb begin
      rs_val = rf_read(rs_f);
      rt_val = rf_read(rt_f);
      rd_val = rf_read(rd_f);
   end

   always_ff @(posedge clk) begin
      if (wb_en) begin
         rf[wb_reg] <= wb_data;
      end
   end

   // load in EX feeding a source read here
   assign stall = id_mem_rd && ((use_rs && id_rd == rs_f) ||
                                (use_rt && id_rd == rt_f) ||
                                (use_rd && id_rd == rd_f));

   // ID/EX control, bubble on stall or flush
   always_ff @(posedge clk) begin
      if (rst) begin
         id_opcode <= op_nop;
         id_reg_wr <= 1'b0;
         id_mem_rd <= 1'b0;
         id_mem_wr <= 1'b0;
      end else if (!halt) begin
         if (flush || stall) begin
            id_opcode <= op_nop;
            id_reg_wr <= 1'b0;
            id_mem_rd <= 1'b0;
            id_mem_wr <= 1'b0;
         end else begin
            id_opcode <= opcode;
            id_reg_wr <= reg_wr;
            id_mem_rd <= (opcode == op_ld);
            id_mem_wr <= (opcode == op_st);
         end
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      if (!halt) begin
         id_alu_op <= alu_op;
         id_wb_src <= wb_src;
         id_rs_val <= rs_val;
         id_rt_val <= rt_val;
         id_rd_val <= rd_val;
         id_imm    <= imm;
         id_pc2    <= if_pc2;
         id_rs     <= rs_f;
         id_rt     <= rt_f;
         id_rd     <= dst;
      end
   end

endmodule

/* source/fetch.sv */
// instruction fetch stage
`include "proc_defs.svh"

module fetch (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  logic                    flush,
   input  logic                    halt,
   input  logic [`PROC_WORD_W-1:0] next_pc,
   input  logic [`PROC_WORD_W-1:0] imem_data,
   output logic [`PROC_WORD_W-1:0] imem_addr,
   output logic [`PROC_WORD_W-1:0] if_instr,
   output logic [`PROC_WORD_W-1:0] if_pc2
);

   logic [`PROC_WORD_W-1:0] pc;
   logic [`PROC_WORD_W-1:0] pc_plus2;

   assign imem_addr = pc;
   assign pc_plus2  = pc + `PROC_WORD_W'(2);

   // pc and fetched word, redirect beats load-use hold
   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= '0;
         if_instr <= `PROC_NOP_WORD;
      end else if (!halt) begin
         if (flush) begin
            pc       <= next_pc;
            if_instr <= `PROC_NOP_WORD;
         end else if (!stall) begin
            pc       <= pc_plus2;
            if_instr <= imem_data;
         end
      end
   end

   // return address travels with the word
   always_ff @(posedge clk) begin
      if (!halt && !stall) begin
         if_pc2 <= pc_plus2;
      end
   end

endmodule

/* source/proc_pkg.sv */
// processor instruction types
package proc_pkg;

   // major opcode, instruction bits 15 to 11
   // codes not listed here are illegal
   typedef enum logic [4:0] {
      op_halt = 5'b00000,
      op_nop  = 5'b00001,
      op_j    = 5'b00100,
      op_addi = 5'b01000,
      op_beqz = 5'b01100,
      op_st   = 5'b10000,
      op_ld   = 5'b10001,
      op_lbi  = 5'b11000,
      op_add  = 5'b11010,
      op_sub  = 5'b11011,
      op_and  = 5'b11100,
      op_xor  = 5'b11101
   } opcode_e;

   // alu function
   typedef enum logic [1:0] {
      alu_add = 2'b00,
      alu_sub = 2'b01,
      alu_and = 2'b10,
      alu_xor = 2'b11
   } alu_op_e;

   // source of the register writeback value
   typedef enum logic [1:0] {
      wb_alu = 2'b00,
      wb_mem = 2'b01,
      wb_pc2 = 2'b10
   } wb_src_e;

endpackage

/* source/proc_defs.svh */
// processor widths and depths
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// data and instruction word width
`define PROC_WORD_W 16

// register file size and index width
`define PROC_REG_CNT 8
`define PROC_REG_AW 3

// data memory depth in words
`define PROC_DMEM_WORDS 256

// nop encoding, opcode 5'b00001 with zero fields
`define PROC_NOP_WORD 16'h0800

`endif
